//--- Bender.yml
package:
  name: sd_cmd_phy

sources:
  - sd_cmd_pkg.sv
  - sd_cmd_regs.sv
  - sd_cmd_receiver.sv
  - sd_resp_transmitter.sv
  - sd_cmd_phy.sv
  - target: test
    files:
      - sd_cmd_properties.sv
      - tb_clock_gen.sv
      - tb_sd_cmd_phy.sv

//--- sd_cmd_patterns.txt
# E idx arg exp_cmd_valid (first line, before power-up wait) | C idx arg corrupt crc_dis exp_good
# R type idx arg data3..data0 go_while_busy exp_bits (0 R1 1 R1b 2 R2 3 R3 4 R6 5 R7) | U addr err
E 00 00000000 0
C 00 00000000 0 0 1
C 08 000001aa 0 0 1
C 37 00000000 1 0 0
C 37 00000000 1 1 1
C 29 40ff8000 0 0 1
C 11 12345678 1 0 0
C 02 00000000 0 1 1
R 0 08 00000900 00000000 00000000 00000000 00000000 0 30
R 3 3f 80ff8000 00000000 00000000 00000000 00000000 0 30
R 2 3f 00000000 1d415344 53443031 10abcdef 01234567 0 88
R 5 08 000001aa 00000000 00000000 00000000 00000000 1 30
R 2 3f 00000000 deadbeef 0badf00d 5a5aa5a5 c3c33c3c 1 88
R 4 03 aaaa0520 00000000 00000000 00000000 00000000 0 30
R 1 07 00000900 00000000 00000000 00000000 00000000 0 30
U 30 1
U fc 1
C 0d aaaa0000 0 0 1

//--- sd_cmd_phy.f
sd_cmd_pkg.sv
sd_cmd_regs.sv
sd_cmd_receiver.sv
sd_resp_transmitter.sv
sd_cmd_phy.sv
sd_cmd_properties.sv
tb_clock_gen.sv
tb_sd_cmd_phy.sv

//--- sd_cmd_phy.sv
// top level of the card-side CMD-line PHY; APB register block, receiver and transmitter
`timescale 1ns/10ps

module sd_cmd_phy (
   input  logic                              sd_clk,
   input  logic                              reset_n,
   input  logic                              psel_i,
   input  logic                              penable_i,
   input  logic                              pwrite_i,
   input  logic [sd_cmd_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic [31:0]                       pwdata_i,
   output logic [31:0]                       prdata_o,
   output logic                              pready_o,
   output logic                              pslverr_o,
   input  logic                              sd_cmd_i,
   output logic                              sd_cmd_o,
   output logic                              sd_cmd_oe_o
);

   sd_cmd_pkg::cmd_status_t cmd_status;
   sd_cmd_pkg::resp_req_t   resp_req;
   logic                    resp_busy;
   logic                    crc_disable;

   sd_cmd_regs i_sd_cmd_regs (
      .sd_clk        (sd_clk),
      .reset_n       (reset_n),
      .psel_i        (psel_i),
      .penable_i     (penable_i),
      .pwrite_i      (pwrite_i),
      .paddr_i       (paddr_i),
      .pwdata_i      (pwdata_i),
      .cmd_status_i  (cmd_status),
      .resp_busy_i   (resp_busy),
      .prdata_o      (prdata_o),
      .pready_o      (pready_o),
      .pslverr_o     (pslverr_o),
      .resp_req_o    (resp_req),
      .crc_disable_o (crc_disable)
   );

   // receiver ignores the line while the transmitter drives it
   sd_cmd_receiver i_sd_cmd_receiver (
      .sd_clk        (sd_clk),
      .reset_n       (reset_n),
      .sd_cmd_i      (sd_cmd_i),
      .sd_cmd_oe_i   (sd_cmd_oe_o),
      .crc_disable_i (crc_disable),
      .cmd_status_o  (cmd_status)
   );

   sd_resp_transmitter i_sd_resp_transmitter (
      .sd_clk      (sd_clk),
      .reset_n     (reset_n),
      .resp_req_i  (resp_req),
      .sd_cmd_o    (sd_cmd_o),
      .sd_cmd_oe_o (sd_cmd_oe_o),
      .resp_busy_o (resp_busy)
   );

endmodule

//--- sd_cmd_pkg.sv
// shared frame widths, APB register map, response types and CRC7 step for the CMD-line PHY
package sd_cmd_pkg;

   // frame lengths on the CMD line
   localparam int unsigned CMD_BITS       = 48;
   localparam int unsigned LONG_RESP_BITS = 136;
   localparam int unsigned CRC7_W         = 7;
   localparam int unsigned CRC_SPAN       = 40;
   localparam int unsigned POWERUP_WAIT   = 60;

   // R2 layout: 8 header bits, 120 content bits taken from 128 register bits
   localparam int unsigned R2_HDR_BITS     = 8;
   localparam int unsigned R2_CONTENT_BITS = 120;
   localparam int unsigned R2_REG_BITS     = 128;
   localparam int unsigned RESP_BODY_W     = R2_HDR_BITS + R2_CONTENT_BITS;

   // counter widths
   localparam int unsigned RX_CNT_W = $clog2(POWERUP_WAIT + CMD_BITS);
   localparam int unsigned TX_CNT_W = $clog2(LONG_RESP_BITS + 1);

   // APB register map
   localparam int unsigned APB_ADDR_W = 8;
   localparam logic [APB_ADDR_W-1:0] REG_CTRL       = 8'h00;
   localparam logic [APB_ADDR_W-1:0] REG_RESP_TYPE  = 8'h04;
   localparam logic [APB_ADDR_W-1:0] REG_RESP_INDEX = 8'h08;
   localparam logic [APB_ADDR_W-1:0] REG_RESP_ARG   = 8'h0C;
   localparam logic [APB_ADDR_W-1:0] REG_RESP_DATA0 = 8'h10;
   localparam logic [APB_ADDR_W-1:0] REG_RESP_DATA1 = 8'h14;
   localparam logic [APB_ADDR_W-1:0] REG_RESP_DATA2 = 8'h18;
   localparam logic [APB_ADDR_W-1:0] REG_RESP_DATA3 = 8'h1C;
   localparam logic [APB_ADDR_W-1:0] REG_RESP_GO    = 8'h20;
   localparam logic [APB_ADDR_W-1:0] REG_STATUS     = 8'h24;
   localparam logic [APB_ADDR_W-1:0] REG_CMD_INDEX  = 8'h28;
   localparam logic [APB_ADDR_W-1:0] REG_CMD_ARG    = 8'h2C;

   typedef enum logic [3:0] {
      R1  = 4'd0,
      R1B = 4'd1,
      R2  = 4'd2,
      R3  = 4'd3,
      R6  = 4'd4,
      R7  = 4'd5
   } resp_type_e;

   // host command as it appears on the line, MSB first
   typedef struct packed {
      logic              start;
      logic              dir;
      logic [5:0]        index;
      logic [31:0]       arg;
      logic [CRC7_W-1:0] crc;
      logic              stop;
   } cmd_frame_t;

   typedef struct packed {
      logic       valid;
      logic       crc_good;
      cmd_frame_t frame;
   } cmd_status_t;

   typedef struct packed {
      logic                       start;
      resp_type_e                 rtype;
      logic [5:0]                 index;
      logic [31:0]                arg;
      logic [R2_CONTENT_BITS-1:0] long_data;
   } resp_req_t;

   // one bit of x^7 + x^3 + 1
   function automatic logic [CRC7_W-1:0] crc7_step(input logic [CRC7_W-1:0] crc,
                                                   input logic din);
      logic fb;
      fb = din ^ crc[CRC7_W-1];
      return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
   endfunction

endpackage

//--- sd_cmd_properties.sv
// concurrent checks on the CMD-line PHY top level, bound into every sd_cmd_phy instance
`timescale 1ns/10ps

module sd_cmd_properties (
   input logic sd_clk,
   input logic reset_n,
   input logic pready_i,
   input logic sd_cmd_oe_i
);

   // APB slave never inserts wait states
   pready_high: assert property (@(posedge sd_clk) pready_i)
      else $error("pready_o dropped low");

   // longest frame on the line is an R2 response
   oe_bounded: assert property (@(posedge sd_clk) disable iff (!reset_n)
      $rose(sd_cmd_oe_i) |-> ##[1:sd_cmd_pkg::LONG_RESP_BITS] !sd_cmd_oe_i)
      else $error("sd_cmd_oe_o held high longer than an R2 frame");

   oe_low_in_reset: assert property (@(posedge sd_clk) !reset_n |-> !sd_cmd_oe_i)
      else $error("sd_cmd_oe_o high while reset_n is low");

endmodule

bind sd_cmd_phy sd_cmd_properties i_sd_cmd_properties (
   .sd_clk      (sd_clk),
   .reset_n     (reset_n),
   .pready_i    (pready_o),
   .sd_cmd_oe_i (sd_cmd_oe_o)
);

//--- sd_cmd_receiver.sv
// CMD-line receiver; waits out power-up clocks, then captures and CRC-checks host commands
`timescale 1ns/10ps

module sd_cmd_receiver (
   input  logic                    sd_clk,
   input  logic                    reset_n,
   input  logic                    sd_cmd_i,
   input  logic                    sd_cmd_oe_i,
   input  logic                    crc_disable_i,
   output sd_cmd_pkg::cmd_status_t cmd_status_o
);

   typedef enum logic [2:0] {
      ST_RESET,
      ST_POWERUP,
      ST_IDLE,
      ST_READ,
      ST_CHECK
   } rx_state_e;

   rx_state_e                             state_q;
   logic [sd_cmd_pkg::RX_CNT_W-1:0]       cnt_q;
   logic                                  cmd_last_q;
   logic [sd_cmd_pkg::CRC7_W-1:0]         crc_q;
   logic                                  valid_q;
   logic                                  crc_good_q;
   logic                                  start_seen;
   sd_cmd_pkg::cmd_frame_t                shift_q;

   // falling edge on CMD while we are not driving it
   assign start_seen = ~sd_cmd_i & cmd_last_q & ~sd_cmd_oe_i;

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state_q    <= ST_RESET;
         cnt_q      <= '0;
         cmd_last_q <= 1'b0;
         crc_q      <= '0;
         valid_q    <= 1'b0;
         crc_good_q <= 1'b0;
      end else begin
         cmd_last_q <= sd_cmd_i;
         valid_q    <= 1'b0;
         case (state_q)
            ST_RESET: begin
               if (sd_cmd_i) begin
                  cnt_q   <= '0;
                  state_q <= ST_POWERUP;
               end
            end
            ST_POWERUP: begin
               // line has to stay high for the whole wait
               if (!sd_cmd_i) begin
                  state_q <= ST_RESET;
               end else if (cnt_q == sd_cmd_pkg::RX_CNT_W'(sd_cmd_pkg::POWERUP_WAIT - 1)) begin
                  state_q <= ST_IDLE;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            ST_IDLE: begin
               if (start_seen) begin
                  cnt_q   <= sd_cmd_pkg::RX_CNT_W'(1);
                  crc_q   <= '0;
                  state_q <= ST_READ;
               end
            end
            ST_READ: begin
               // start bit is zero, so skipping it leaves the crc unchanged
               if (cnt_q < sd_cmd_pkg::RX_CNT_W'(sd_cmd_pkg::CRC_SPAN)) begin
                  crc_q <= sd_cmd_pkg::crc7_step(crc_q, sd_cmd_i);
               end
               if (cnt_q == sd_cmd_pkg::RX_CNT_W'(sd_cmd_pkg::CMD_BITS - 1)) begin
                  state_q <= ST_CHECK;
               end
               cnt_q <= cnt_q + 1'b1;
            end
            ST_CHECK: begin
               valid_q    <= 1'b1;
               crc_good_q <= crc_disable_i | (shift_q.crc == crc_q);
               state_q    <= ST_IDLE;
            end
            default: state_q <= ST_RESET;
         endcase
      end
   end

   // frame shift register
   always_ff @(posedge sd_clk) begin
      if (state_q == ST_IDLE && start_seen) begin
         shift_q <= '0;
      end else if (state_q == ST_READ) begin
         shift_q <= {shift_q[sd_cmd_pkg::CMD_BITS-2:0], sd_cmd_i};
      end
   end

   assign cmd_status_o.valid    = valid_q;
   assign cmd_status_o.crc_good = crc_good_q;
   assign cmd_status_o.frame    = shift_q;

endmodule

//--- sd_cmd_regs.sv
// APB register block of the CMD-line PHY; holds response setup and the last command status
`timescale 1ns/10ps

module sd_cmd_regs (
   input  logic                                sd_clk,
   input  logic                                reset_n,
   input  logic                                psel_i,
   input  logic                                penable_i,
   input  logic                                pwrite_i,
   input  logic [sd_cmd_pkg::APB_ADDR_W-1:0]   paddr_i,
   input  logic [31:0]                         pwdata_i,
   input  sd_cmd_pkg::cmd_status_t             cmd_status_i,
   input  logic                                resp_busy_i,
   output logic [31:0]                         prdata_o,
   output logic                                pready_o,
   output logic                                pslverr_o,
   output sd_cmd_pkg::resp_req_t               resp_req_o,
   output logic                                crc_disable_o
);

   logic                                   apb_access;
   logic                                   apb_wr;
   logic                                   go_req;
   logic                                   addr_hit;
   logic                                   crc_disable_q;
   logic                                   cmd_valid_q;
   logic                                   crc_good_q;
   logic [5:0]                             cmd_index_q;
   logic [31:0]                            cmd_arg_q;
   sd_cmd_pkg::resp_type_e                 rtype_q;
   logic [5:0]                             resp_index_q;
   logic [31:0]                            resp_arg_q;
   logic [sd_cmd_pkg::R2_REG_BITS-1:0]     resp_data_q;

   assign apb_access = psel_i & penable_i;
   assign apb_wr     = apb_access & pwrite_i;
   assign go_req     = apb_wr & (paddr_i == sd_cmd_pkg::REG_RESP_GO);

   // no wait states
   assign pready_o  = 1'b1;
   assign pslverr_o = apb_access & (~addr_hit | (go_req & resp_busy_i));

   always_comb begin
      addr_hit = 1'b1;
      prdata_o = '0;
      case (paddr_i)
         sd_cmd_pkg::REG_CTRL:       prdata_o = {31'b0, crc_disable_q};
         sd_cmd_pkg::REG_RESP_TYPE:  prdata_o = {28'b0, rtype_q};
         sd_cmd_pkg::REG_RESP_INDEX: prdata_o = {26'b0, resp_index_q};
         sd_cmd_pkg::REG_RESP_ARG:   prdata_o = resp_arg_q;
         sd_cmd_pkg::REG_RESP_DATA0: prdata_o = resp_data_q[31:0];
         sd_cmd_pkg::REG_RESP_DATA1: prdata_o = resp_data_q[63:32];
         sd_cmd_pkg::REG_RESP_DATA2: prdata_o = resp_data_q[95:64];
         sd_cmd_pkg::REG_RESP_DATA3: prdata_o = resp_data_q[127:96];
         sd_cmd_pkg::REG_RESP_GO:    prdata_o = '0;
         sd_cmd_pkg::REG_STATUS:     prdata_o = {29'b0, crc_good_q, cmd_valid_q, resp_busy_i};
         sd_cmd_pkg::REG_CMD_INDEX:  prdata_o = {26'b0, cmd_index_q};
         sd_cmd_pkg::REG_CMD_ARG:    prdata_o = cmd_arg_q;
         default:                    addr_hit = 1'b0;
      endcase
   end

   // control and captured command status
   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         crc_disable_q <= 1'b0;
         cmd_valid_q   <= 1'b0;
         crc_good_q    <= 1'b0;
         cmd_index_q   <= '0;
         cmd_arg_q     <= '0;
      end else begin
         if (apb_wr && paddr_i == sd_cmd_pkg::REG_CTRL) begin
            crc_disable_q <= pwdata_i[0];
         end
         // new command wins over a clear in the same cycle
         if (cmd_status_i.valid) begin
            cmd_valid_q <= 1'b1;
            crc_good_q  <= cmd_status_i.crc_good;
            cmd_index_q <= cmd_status_i.frame.index;
            cmd_arg_q   <= cmd_status_i.frame.arg;
         end else if (apb_wr && paddr_i == sd_cmd_pkg::REG_STATUS && pwdata_i[1]) begin
            cmd_valid_q <= 1'b0;
         end
      end
   end

   // response setup
   always_ff @(posedge sd_clk) begin
      if (apb_wr) begin
         case (paddr_i)
            sd_cmd_pkg::REG_RESP_TYPE:  rtype_q <= sd_cmd_pkg::resp_type_e'(pwdata_i[3:0]);
            sd_cmd_pkg::REG_RESP_INDEX: resp_index_q <= pwdata_i[5:0];
            sd_cmd_pkg::REG_RESP_ARG:   resp_arg_q <= pwdata_i;
            sd_cmd_pkg::REG_RESP_DATA0: resp_data_q[31:0] <= pwdata_i;
            sd_cmd_pkg::REG_RESP_DATA1: resp_data_q[63:32] <= pwdata_i;
            sd_cmd_pkg::REG_RESP_DATA2: resp_data_q[95:64] <= pwdata_i;
            sd_cmd_pkg::REG_RESP_DATA3: resp_data_q[127:96] <= pwdata_i;
            default: ;
         endcase
      end
   end

   // start is refused while a response is on the line
   assign resp_req_o.start     = go_req & ~resp_busy_i;
   assign resp_req_o.rtype     = rtype_q;
   assign resp_req_o.index     = resp_index_q;
   assign resp_req_o.arg       = resp_arg_q;
   assign resp_req_o.long_data =
      resp_data_q[sd_cmd_pkg::R2_REG_BITS-1 -: sd_cmd_pkg::R2_CONTENT_BITS];

   assign crc_disable_o = crc_disable_q;

endmodule

//--- sd_resp_transmitter.sv
// CMD-line response transmitter; sends 48-bit or R2 136-bit frames with CRC7 and end bit
`timescale 1ns/10ps

module sd_resp_transmitter (
   input  logic                  sd_clk,
   input  logic                  reset_n,
   input  sd_cmd_pkg::resp_req_t resp_req_i,
   output logic                  sd_cmd_o,
   output logic                  sd_cmd_oe_o,
   output logic                  resp_busy_o
);

   typedef enum logic {
      ST_IDLE,
      ST_SEND
   } tx_state_e;

   tx_state_e                             state_q;
   logic [sd_cmd_pkg::TX_CNT_W-1:0]       bit_cnt_q;
   logic                                  sd_cmd_q;
   logic                                  oe_q;
   logic [sd_cmd_pkg::RESP_BODY_W-1:0]    shift_q;
   logic [sd_cmd_pkg::CRC7_W-1:0]         crc_q;
   logic                                  is_long_q;
   logic                                  is_r3_q;
   logic [sd_cmd_pkg::TX_CNT_W-1:0]       total_bits;
   logic [sd_cmd_pkg::TX_CNT_W-1:0]       data_bits;
   logic [sd_cmd_pkg::TX_CNT_W-1:0]       crc_first;
   logic                                  in_data;
   logic                                  in_crc;
   logic                                  frame_done;
   logic                                  tx_bit;

   assign total_bits = is_long_q ? sd_cmd_pkg::TX_CNT_W'(sd_cmd_pkg::LONG_RESP_BITS)
                                 : sd_cmd_pkg::TX_CNT_W'(sd_cmd_pkg::CMD_BITS);
   // crc and end bit take the last eight positions
   assign data_bits  = total_bits - sd_cmd_pkg::TX_CNT_W'(sd_cmd_pkg::CRC7_W + 1);
   // R2 crc covers the content only, not the header
   assign crc_first  = is_long_q ? sd_cmd_pkg::TX_CNT_W'(sd_cmd_pkg::R2_HDR_BITS) : '0;

   assign in_data    = bit_cnt_q < data_bits;
   assign in_crc     = bit_cnt_q < total_bits - 1'b1;
   assign frame_done = bit_cnt_q == total_bits;

   // R3 carries all ones in place of the crc
   assign tx_bit = in_data ? shift_q[sd_cmd_pkg::RESP_BODY_W-1]
                 : in_crc  ? (crc_q[sd_cmd_pkg::CRC7_W-1] | is_r3_q)
                 : 1'b1;

   // first cycle in ST_SEND is the preamble, outputs are one edge behind
   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state_q   <= ST_IDLE;
         bit_cnt_q <= '0;
         sd_cmd_q  <= 1'b1;
         oe_q      <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (resp_req_i.start) begin
                  bit_cnt_q <= '0;
                  state_q   <= ST_SEND;
               end
            end
            ST_SEND: begin
               if (frame_done) begin
                  oe_q     <= 1'b0;
                  sd_cmd_q <= 1'b1;
                  state_q  <= ST_IDLE;
               end else begin
                  oe_q      <= 1'b1;
                  sd_cmd_q  <= tx_bit;
                  bit_cnt_q <= bit_cnt_q + 1'b1;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // frame body and crc
   always_ff @(posedge sd_clk) begin
      if (state_q == ST_IDLE && resp_req_i.start) begin
         is_long_q <= resp_req_i.rtype == sd_cmd_pkg::R2;
         is_r3_q   <= resp_req_i.rtype == sd_cmd_pkg::R3;
         crc_q     <= '0;
         if (resp_req_i.rtype == sd_cmd_pkg::R2) begin
            shift_q <= {2'b00, {(sd_cmd_pkg::R2_HDR_BITS - 2){1'b1}}, resp_req_i.long_data};
         end else begin
            shift_q <= {1'b0, 1'b0, resp_req_i.index, resp_req_i.arg,
                        {(sd_cmd_pkg::RESP_BODY_W - sd_cmd_pkg::CRC_SPAN){1'b0}}};
         end
      end else if (state_q == ST_SEND && !frame_done) begin
         if (in_data) begin
            shift_q <= {shift_q[sd_cmd_pkg::RESP_BODY_W-2:0], 1'b0};
            if (bit_cnt_q >= crc_first) begin
               crc_q <= sd_cmd_pkg::crc7_step(crc_q, shift_q[sd_cmd_pkg::RESP_BODY_W-1]);
            end
         end else begin
            crc_q <= {crc_q[sd_cmd_pkg::CRC7_W-2:0], 1'b0};
         end
      end
   end

   assign sd_cmd_o    = sd_cmd_q;
   assign sd_cmd_oe_o = oe_q;
   assign resp_busy_o = state_q == ST_SEND;

endmodule

//--- tb_clock_gen.sv
// free-running sd_clk source for the CMD-line PHY testbench, 8 ns period
`timescale 1ns/10ps

module tb_clock_gen (
   output logic sd_clk_o
);

   // half period of 4 ns
   initial begin
      sd_clk_o = 1'b0;
      forever begin
         #4 sd_clk_o = ~sd_clk_o;
      end
   end

endmodule

//--- tb_sd_cmd_phy.sv
// testbench top of the CMD-line PHY; plays APB master and SD host from sd_cmd_patterns.txt
`timescale 1ns/10ps

module tb_sd_cmd_phy;

   logic        sd_clk;
   logic        reset_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        sd_cmd_in;
   logic        sd_cmd_out;
   logic        sd_cmd_oe;
   int unsigned value_errors;
   int unsigned other_errors;
   int unsigned cycle_cnt;
   int unsigned cycle_limit;
   string       lines[$];
   logic        resp_bits[$];

   tb_clock_gen i_tb_clock_gen (.sd_clk_o(sd_clk));

   sd_cmd_phy i_sd_cmd_phy (
      .sd_clk      (sd_clk),
      .reset_n     (reset_n),
      .psel_i      (psel),
      .penable_i   (penable),
      .pwrite_i    (pwrite),
      .paddr_i     (paddr),
      .pwdata_i    (pwdata),
      .prdata_o    (prdata),
      .pready_o    (pready),
      .pslverr_o   (pslverr),
      .sd_cmd_i    (sd_cmd_in),
      .sd_cmd_o    (sd_cmd_out),
      .sd_cmd_oe_o (sd_cmd_oe)
   );

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("FAILED t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond) else begin
         $display("ERROR t=%0t %s", $time, what);
         other_errors++;
      end
   endtask

   task automatic print_counts;
      $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
   endtask

   // x^7 + x^3 + 1, MSB first, register starts at zero
   function automatic logic [6:0] crc7_calc(input logic [127:0] data, input int nbits);
      logic [6:0] c;
      logic       top;
      int         i;
      c = '0;
      for (i = nbits - 1; i >= 0; i--) begin
         top = c[6] ^ data[i];
         c   = c << 1;
         if (top) begin
            c = c ^ 7'h09;
         end
      end
      return c;
   endfunction

   function automatic logic [47:0] build_cmd(input logic [5:0] index, input logic [31:0] arg,
                                             input logic corrupt);
      logic [39:0] head;
      logic [6:0]  crc;
      head = {1'b0, 1'b1, index, arg};
      crc  = crc7_calc({88'b0, head}, 40);
      if (corrupt) begin
         crc = crc ^ 7'h01;
      end
      return {head, crc, 1'b1};
   endfunction

   // setup phase, access phase, sampled mid-cycle where prdata and pslverr are stable
   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      @(posedge sd_clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge sd_clk);
      #1;
      penable = 1'b1;
      @(negedge sd_clk);
      rdata = prdata;
      err   = pslverr;
      check_value("pready_o", 32'h1, {31'b0, pready});
      @(posedge sd_clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b1, addr, data, rd, err);
      check_value($sformatf("pslverr_o on write to 0x%0h", addr), {31'b0, exp_err}, {31'b0, err});
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      logic err;
      apb_xfer(1'b0, addr, 32'h0, data, err);
      check_value($sformatf("pslverr_o on read of 0x%0h", addr), 32'h0, {31'b0, err});
   endtask

   task automatic send_frame(input logic [47:0] frame);
      int i;
      for (i = 47; i >= 0; i--) begin
         @(posedge sd_clk);
         #1;
         sd_cmd_in = frame[i];
      end
      @(posedge sd_clk);
      #1;
      sd_cmd_in = 1'b1;
   endtask

   task automatic run_early(input string line);
      logic [31:0] idx;
      logic [31:0] arg;
      logic [31:0] exp_valid;
      logic [31:0] rd;
      int          n;
      n = $sscanf(line, "E %h %h %h", idx, arg, exp_valid);
      check_true(n == 3, {"malformed pattern line: ", line});
      send_frame(build_cmd(idx[5:0], arg, 1'b0));
      repeat (4) @(posedge sd_clk);
      apb_read(sd_cmd_pkg::REG_STATUS, rd);
      check_value("REG_STATUS.cmd_valid", exp_valid, {31'b0, rd[1]});
      // line must now stay high for a full power-up wait
      repeat (sd_cmd_pkg::POWERUP_WAIT + 20) @(posedge sd_clk);
   endtask

   task automatic run_command(input string line);
      logic [31:0] idx;
      logic [31:0] arg;
      logic [31:0] corrupt;
      logic [31:0] dis;
      logic [31:0] exp_good;
      logic [31:0] rd;
      int          n;
      int          polls;
      n = $sscanf(line, "C %h %h %h %h %h", idx, arg, corrupt, dis, exp_good);
      check_true(n == 5, {"malformed pattern line: ", line});
      check_true(exp_good[0] == (dis[0] | ~corrupt[0]),
                 {"expected crc_good disagrees with its own fields: ", line});
      apb_write(sd_cmd_pkg::REG_CTRL, {31'b0, dis[0]}, 1'b0);
      send_frame(build_cmd(idx[5:0], arg, corrupt[0]));
      rd    = '0;
      polls = 0;
      while (!rd[1] && polls < 10) begin
         apb_read(sd_cmd_pkg::REG_STATUS, rd);
         polls++;
      end
      check_true(rd[1], "cmd_valid was never set after a command frame");
      check_value("REG_STATUS.crc_good", {31'b0, exp_good[0]}, {31'b0, rd[2]});
      apb_read(sd_cmd_pkg::REG_CMD_INDEX, rd);
      check_value("REG_CMD_INDEX", {26'b0, idx[5:0]}, rd);
      apb_read(sd_cmd_pkg::REG_CMD_ARG, rd);
      check_value("REG_CMD_ARG", arg, rd);
      // sticky bit clears on a write of 1
      apb_write(sd_cmd_pkg::REG_STATUS, 32'h2, 1'b0);
      apb_read(sd_cmd_pkg::REG_STATUS, rd);
      check_value("REG_STATUS.cmd_valid", 32'h0, {31'b0, rd[1]});
   endtask

   task automatic collect_response;
      int   waited;
      logic seen;
      resp_bits.delete();
      waited = 0;
      seen   = 1'b0;
      while (waited < 200) begin
         @(negedge sd_clk);
         waited++;
         if (sd_cmd_oe) begin
            seen = 1'b1;
            resp_bits.push_back(sd_cmd_out);
         end else if (seen) begin
            break;
         end
      end
      check_true(seen && !sd_cmd_oe, "response frame did not start and end on the CMD line");
   endtask

   // setup registers change under a running frame, which must not reach the line
   task automatic go_while_busy(input logic [31:0] other_arg);
      logic [31:0] rd;
      apb_read(sd_cmd_pkg::REG_STATUS, rd);
      check_true(rd[0], "REG_STATUS did not show resp_busy during a response");
      apb_write(sd_cmd_pkg::REG_RESP_ARG, other_arg, 1'b0);
      apb_write(sd_cmd_pkg::REG_RESP_DATA3, other_arg, 1'b0);
      apb_write(sd_cmd_pkg::REG_RESP_GO, 32'h1, 1'b1);
   endtask

   task automatic run_response(input string line);
      logic [31:0]  rtype;
      logic [31:0]  idx;
      logic [31:0]  arg;
      logic [31:0]  d3;
      logic [31:0]  d2;
      logic [31:0]  d1;
      logic [31:0]  d0;
      logic [31:0]  busy_go;
      logic [31:0]  exp_bits;
      logic [31:0]  rd;
      logic [127:0] content;
      logic [39:0]  head;
      logic [6:0]   crc;
      logic [135:0] exp_frame;
      int           n;
      int           nbits;
      int           i;
      n = $sscanf(line, "R %h %h %h %h %h %h %h %h %h",
                  rtype, idx, arg, d3, d2, d1, d0, busy_go, exp_bits);
      check_true(n == 9, {"malformed pattern line: ", line});
      content = {d3, d2, d1, d0};
      if (rtype == 32'(sd_cmd_pkg::R2)) begin
         crc       = crc7_calc({8'b0, content[127:8]}, 120);
         exp_frame = {8'b00111111, content[127:8], crc, 1'b1};
         nbits     = 136;
      end else begin
         head      = {2'b00, idx[5:0], arg};
         crc       = (rtype == 32'(sd_cmd_pkg::R3)) ? 7'h7f : crc7_calc({88'b0, head}, 40);
         exp_frame = {88'b0, head, crc, 1'b1};
         nbits     = 48;
      end
      check_true(exp_bits == nbits, {"expected bit count disagrees with the type: ", line});
      apb_write(sd_cmd_pkg::REG_RESP_TYPE, rtype, 1'b0);
      apb_write(sd_cmd_pkg::REG_RESP_INDEX, idx, 1'b0);
      apb_write(sd_cmd_pkg::REG_RESP_ARG, arg, 1'b0);
      apb_write(sd_cmd_pkg::REG_RESP_DATA0, d0, 1'b0);
      apb_write(sd_cmd_pkg::REG_RESP_DATA1, d1, 1'b0);
      apb_write(sd_cmd_pkg::REG_RESP_DATA2, d2, 1'b0);
      apb_write(sd_cmd_pkg::REG_RESP_DATA3, d3, 1'b0);
      apb_write(sd_cmd_pkg::REG_RESP_GO, 32'h1, 1'b0);
      fork
         collect_response();
         if (busy_go[0]) go_while_busy(~arg);
      join
      check_value("sd_cmd_oe_o high cycles", exp_bits, resp_bits.size());
      for (i = 0; i < resp_bits.size() && i < nbits; i++) begin
         check_value($sformatf("sd_cmd_o bit %0d", i),
                     {31'b0, exp_frame[nbits-1-i]}, {31'b0, resp_bits[i]});
      end
      apb_read(sd_cmd_pkg::REG_STATUS, rd);
      check_value("REG_STATUS.resp_busy", 32'h0, {31'b0, rd[0]});
   endtask

   task automatic run_unmapped(input string line);
      logic [31:0] addr;
      logic [31:0] exp_err;
      logic [31:0] rd;
      logic        err;
      int          n;
      n = $sscanf(line, "U %h %h", addr, exp_err);
      check_true(n == 2, {"malformed pattern line: ", line});
      apb_xfer(1'b0, addr[7:0], 32'h0, rd, err);
      check_value($sformatf("pslverr_o on read of 0x%0h", addr[7:0]), exp_err, {31'b0, err});
   endtask

   // watchdog sized from the number of pattern lines
   always @(posedge sd_clk) begin
      cycle_cnt++;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
         $display("ERROR t=%0t run did not finish within %0d cycles", $time, cycle_limit);
         other_errors++;
         print_counts();
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      int          fd;
      string       line;
      logic [31:0] rd;
      cycle_cnt    = 0;
      cycle_limit  = 0;
      value_errors = 0;
      other_errors = 0;
      reset_n      = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      sd_cmd_in    = 1'b1;
      fd = $fopen("sd_cmd_patterns.txt", "r");
      check_true(fd != 0, "cannot open sd_cmd_patterns.txt");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
               lines.push_back(line);
            end
         end
         $fclose(fd);
      end
      cycle_limit = 100 + 200 * lines.size();
      repeat (16) @(posedge sd_clk);
      #1;
      reset_n = 1'b1;
      @(negedge sd_clk);
      check_value("sd_cmd_oe_o", 32'h0, {31'b0, sd_cmd_oe});
      apb_read(sd_cmd_pkg::REG_STATUS, rd);
      check_value("REG_STATUS", 32'h0, rd);
      foreach (lines[i]) begin
         case (lines[i][0])
            "E": run_early(lines[i]);
            "C": run_command(lines[i]);
            "R": run_response(lines[i]);
            "U": run_unmapped(lines[i]);
            default: check_true(1'b0, {"unknown pattern kind: ", lines[i]});
         endcase
      end
      repeat (4) @(posedge sd_clk);
      print_counts();
      if (value_errors + other_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
